/* verilog/sbPkg.sv */
package sbPkg;

    // ==============================
    // entry commands
    // ==============================

    // issued by the controller, one per cycle.
    typedef enum logic [1:0] {
        cmdNone  = 2'd0,
        cmdWrite = 2'd1,
        cmdPop   = 2'd2
    } entryCmdE;

    // ==============================
    // controller states
    // ==============================

    // stRespond is the one cycle in which cpuAck is high.
    typedef enum logic [2:0] {
        stIdle     = 3'd0,
        stStoreAck = 3'd1,
        stLoadAck  = 3'd2,
        stLoadMem  = 3'd3,
        stDrain    = 3'd4,
        stRespond  = 3'd5
    } ctrlStateE;

endpackage

/* verilog/storeBufferEntries.sv */
`timescale 1ns/1ns

module storeBufferEntries #(
    parameter int numEntries = 4,
    parameter int addrWidth  = 32,
    parameter int dataWidth  = 32
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  sbPkg::entryCmdE      entryCmd,
    input  logic [addrWidth-1:0] cpuAdr,
    input  logic [dataWidth-1:0] cpuDatW,
    output logic                 hit,
    output logic                 full,
    output logic                 empty,
    output logic [dataWidth-1:0] hitData,
    output logic [addrWidth-1:0] headAdr,
    output logic [dataWidth-1:0] headDat
);
    import sbPkg::*;

    localparam int ptrWidth = (numEntries > 1) ? $clog2(numEntries) : 1;
    localparam int cntWidth = ptrWidth + 1;

    logic [addrWidth-1:0] adrMem [numEntries];
    logic [dataWidth-1:0] datMem [numEntries];
    logic [numEntries-1:0] valid;

    logic [ptrWidth-1:0] head;
    logic [ptrWidth-1:0] tail;
    logic [cntWidth-1:0] count;
    logic [ptrWidth-1:0] hitIdx;

    logic doWrite;
    logic doAlloc;
    logic doPop;

    // ==============================
    // lookup
    // ==============================

    // all valid entries are compared at once.
    // addresses are unique in the buffer, so at most one matches.
    always_comb begin
        hit    = 1'b0;
        hitIdx = '0;
        for (int i = 0; i < numEntries; i++) begin
            if (valid[i] && (adrMem[i] == cpuAdr)) begin
                hit    = 1'b1;
                hitIdx = ptrWidth'(i);
            end
        end
    end

    assign hitData = datMem[hitIdx];
    assign headAdr = adrMem[head];
    assign headDat = datMem[head];

    assign full  = (count == cntWidth'(numEntries));
    assign empty = (count == '0);

    // ==============================
    // command decode
    // ==============================

    assign doWrite = (entryCmd == cmdWrite);
    // a miss on a full buffer never allocates.
    assign doAlloc = doWrite && !hit && !full;
    assign doPop   = (entryCmd == cmdPop) && !empty;

    // payload arrays.
    always_ff @(posedge clk) begin
        if (doWrite && hit) begin
            datMem[hitIdx] <= cpuDatW;
        end else if (doAlloc) begin
            adrMem[tail] <= cpuAdr;
            datMem[tail] <= cpuDatW;
        end
    end

    // valid bits and pointers.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            valid <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (doAlloc) begin
                valid[tail] <= 1'b1;
                tail        <= tail + 1'b1;
                count       <= count + 1'b1;
            end else if (doPop) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
                count       <= count - 1'b1;
            end
        end
    end

endmodule

/* verilog/drainTimer.sv */
`timescale 1ns/1ns

module drainTimer #(
    parameter int drainIdle = 8
) (
    input  logic clk,
    input  logic rstN,
    input  logic cpuBusy,
    input  logic ctrlIdle,
    input  logic empty,
    output logic drainReq
);

    localparam int cntWidth = (drainIdle > 1) ? $clog2(drainIdle) : 1;

    logic [cntWidth-1:0] idleCnt;
    logic                idleCycle;

    // a cycle counts only with work waiting and nobody on the port.
    assign idleCycle = !cpuBusy && ctrlIdle && !empty;

    // fires on the last idle cycle of the window.
    // a request in the same cycle keeps this low.
    assign drainReq = idleCycle && (idleCnt == cntWidth'(drainIdle - 1));

    // restarts after each pulse, so one drain per window.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            idleCnt <= '0;
        end else if (!idleCycle || drainReq) begin
            idleCnt <= '0;
        end else begin
            idleCnt <= idleCnt + 1'b1;
        end
    end

endmodule

/* verilog/sbController.sv */
`timescale 1ns/1ns

module sbController #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 cpuCyc,
    input  logic                 cpuStb,
    input  logic                 cpuWe,
    input  logic                 hit,
    input  logic                 full,
    input  logic                 drainReq,
    input  logic                 memAck,
    input  logic [dataWidth-1:0] memDatR,
    input  logic [dataWidth-1:0] hitData,
    output logic                 cpuAck,
    output logic [dataWidth-1:0] cpuDatR,
    output logic                 cpuBusy,
    output logic                 ctrlIdle,
    output sbPkg::entryCmdE      entryCmd,
    output logic                 memCyc,
    output logic                 memStb,
    output logic                 memWe
);
    import sbPkg::*;

    ctrlStateE state;
    ctrlStateE nextState;

    logic cpuReq;
    logic storeBlocked;
    // set while a drain was forced by a store into a full buffer.
    logic drainForStore;

    assign cpuReq       = cpuCyc && cpuStb;
    assign storeBlocked = full && !hit;

    // ==============================
    // state machine
    // ==============================

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (cpuReq) begin
                    if (cpuWe) begin
                        nextState = storeBlocked ? stDrain : stStoreAck;
                    end else begin
                        nextState = hit ? stLoadAck : stLoadMem;
                    end
                end else if (drainReq) begin
                    nextState = stDrain;
                end
            end
            stStoreAck: begin
                nextState = stRespond;
            end
            stLoadAck: begin
                nextState = stRespond;
            end
            stLoadMem: begin
                if (memAck) begin
                    nextState = stRespond;
                end
            end
            stDrain: begin
                // back to the waiting store, otherwise let idle decode.
                if (memAck) begin
                    nextState = drainForStore ? stStoreAck : stIdle;
                end
            end
            stRespond: begin
                nextState = stIdle;
            end
            default: begin
                nextState = stIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            drainForStore <= 1'b0;
        end else if (state == stIdle && cpuReq && cpuWe && storeBlocked) begin
            drainForStore <= 1'b1;
        end else if (state == stDrain && memAck) begin
            drainForStore <= 1'b0;
        end
    end

    // ==============================
    // load data
    // ==============================

    always_ff @(posedge clk) begin
        if (state == stLoadAck) begin
            cpuDatR <= hitData;
        end else if (state == stLoadMem && memAck) begin
            cpuDatR <= memDatR;
        end
    end

    // ==============================
    // outputs
    // ==============================

    assign cpuAck   = (state == stRespond);
    assign ctrlIdle = (state == stIdle);
    assign cpuBusy  = cpuReq ||
                      (state == stStoreAck) ||
                      (state == stLoadAck) ||
                      (state == stLoadMem) ||
                      (state == stRespond);

    // bus signals come straight from the state, so they hold until memAck.
    assign memCyc = (state == stLoadMem) || (state == stDrain);
    assign memStb = (state == stLoadMem) || (state == stDrain);
    assign memWe  = (state == stDrain);

    // the write lands on the edge that raises cpuAck.
    always_comb begin
        entryCmd = cmdNone;
        if (state == stStoreAck) begin
            entryCmd = cmdWrite;
        end else if (state == stDrain && memAck) begin
            entryCmd = cmdPop;
        end
    end

endmodule

/* verilog/storeBufferTop.sv */
`timescale 1ns/1ns

module storeBufferTop #(
    parameter int numEntries = 4,
    parameter int addrWidth  = 32,
    parameter int dataWidth  = 32,
    parameter int drainIdle  = 8
) (
    input  logic                 clk,
    input  logic                 rstN,

    // cpu slave port.
    input  logic                 cpuCyc,
    input  logic                 cpuStb,
    input  logic                 cpuWe,
    input  logic [addrWidth-1:0] cpuAdr,
    input  logic [dataWidth-1:0] cpuDatW,
    output logic [dataWidth-1:0] cpuDatR,
    output logic                 cpuAck,

    // memory master port.
    output logic                 memCyc,
    output logic                 memStb,
    output logic                 memWe,
    output logic [addrWidth-1:0] memAdr,
    output logic [dataWidth-1:0] memDatW,
    input  logic [dataWidth-1:0] memDatR,
    input  logic                 memAck
);
    import sbPkg::*;

    entryCmdE             entryCmd;
    logic                 hit;
    logic                 full;
    logic                 empty;
    logic [dataWidth-1:0] hitData;
    logic [addrWidth-1:0] headAdr;
    logic [dataWidth-1:0] headDat;
    logic                 cpuBusy;
    logic                 ctrlIdle;
    logic                 drainReq;

    // ==============================
    // blocks
    // ==============================

    storeBufferEntries #(
        .numEntries (numEntries),
        .addrWidth  (addrWidth),
        .dataWidth  (dataWidth)
    ) storeBufferEntries_inst (
        .clk      (clk),
        .rstN     (rstN),
        .entryCmd (entryCmd),
        .cpuAdr   (cpuAdr),
        .cpuDatW  (cpuDatW),
        .hit      (hit),
        .full     (full),
        .empty    (empty),
        .hitData  (hitData),
        .headAdr  (headAdr),
        .headDat  (headDat)
    );

    drainTimer #(
        .drainIdle (drainIdle)
    ) drainTimer_inst (
        .clk      (clk),
        .rstN     (rstN),
        .cpuBusy  (cpuBusy),
        .ctrlIdle (ctrlIdle),
        .empty    (empty),
        .drainReq (drainReq)
    );

    sbController #(
        .dataWidth (dataWidth)
    ) sbController_inst (
        .clk      (clk),
        .rstN     (rstN),
        .cpuCyc   (cpuCyc),
        .cpuStb   (cpuStb),
        .cpuWe    (cpuWe),
        .hit      (hit),
        .full     (full),
        .drainReq (drainReq),
        .memAck   (memAck),
        .memDatR  (memDatR),
        .hitData  (hitData),
        .cpuAck   (cpuAck),
        .cpuDatR  (cpuDatR),
        .cpuBusy  (cpuBusy),
        .ctrlIdle (ctrlIdle),
        .entryCmd (entryCmd),
        .memCyc   (memCyc),
        .memStb   (memStb),
        .memWe    (memWe)
    );

    // drains write the head entry, load misses read at the cpu address.
    assign memAdr  = memWe ? headAdr : cpuAdr;
    assign memDatW = memWe ? headDat : '0;

endmodule

/* tb/storeBufferTop_props.sv */
`timescale 1ns/1ns

module storeBufferTopProps #(
    parameter int addrWidth = 32,
    parameter int dataWidth = 32
) (
    input logic                 clk,
    input logic                 rstN,
    input logic                 cpuStb,
    input logic                 cpuAck,
    input logic                 memCyc,
    input logic                 memStb,
    input logic                 memWe,
    input logic                 memAck,
    input logic [addrWidth-1:0] memAdr,
    input logic [dataWidth-1:0] memDatW
);

    int failCount = 0;

    stbInCycle: assert property (@(posedge clk) disable iff (!rstN) memStb |-> memCyc)
    else begin
        failCount++;
        $error("memStb high outside a memory cycle");
    end

    // master holds the whole request until the slave acks.
    memHold: assert property (@(posedge clk) disable iff (!rstN)
        memStb && !memAck |=> memStb && $stable(memAdr) && $stable(memDatW) && $stable(memWe))
    else begin
        failCount++;
        $error("memory request changed before memAck");
    end

    ackWithStb: assert property (@(posedge clk) disable iff (!rstN) cpuAck |-> cpuStb)
    else begin
        failCount++;
        $error("cpuAck high without cpuStb");
    end

endmodule

bind storeBufferTop storeBufferTopProps #(
    .addrWidth (addrWidth),
    .dataWidth (dataWidth)
) storeBufferTopProps_inst (.*);

/* tb/storeBufferChecker.sv */
`timescale 1ns/1ns

module storeBufferChecker #(
    parameter int numEntries = 4,
    parameter int memDepth   = 256
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        cpuCyc,
    input  logic        cpuStb,
    input  logic        cpuWe,
    input  logic [31:0] cpuAdr,
    input  logic [31:0] cpuDatW,
    input  logic [31:0] cpuDatR,
    input  logic        cpuAck,
    input  logic        memCyc,
    input  logic        memStb,
    input  logic        memWe,
    input  logic        memAck,
    input  logic [31:0] memAdr,
    input  logic [31:0] memDatW,
    input  logic        finalCheck,
    input  logic [31:0] memImage [memDepth],
    output int          valueErrors,
    output int          otherErrors
);

    logic [31:0] archMem [memDepth];
    logic [31:0] fifoAdr [$];
    logic [31:0] fifoDat [$];
    logic [31:0] reqAdr;
    logic        reqWe;
    logic        pending = 1'b0;
    logic        rstPrev = 1'b0;
    logic        expectTwo;
    logic        expectDrain;
    logic        sawDrain;
    int          cycle = 0;
    int          startCycle;
    int          valueCnt = 0;
    int          otherCnt = 0;

    assign valueErrors = valueCnt;
    assign otherErrors = otherCnt;

    function automatic logic [31:0] initialWord(input logic [31:0] adr);
        return (adr * 32'h9E3779B1) ^ 32'hC3A50000;
    endfunction

    function automatic int findEntry(input logic [31:0] adr);
        for (int i = 0; i < fifoAdr.size(); i++) begin
            if (fifoAdr[i] == adr) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic reportValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("FAIL time %0t %s expected %0h actual %0h", $time, name, expected, actual);
        valueCnt++;
    endtask

    task automatic reportOther(input string msg);
        $display("error at time %0t: %s", $time, msg);
        otherCnt++;
    endtask

    always @(posedge clk) begin
        int idx;
        cycle++;
        if (rstPrev && ({cpuAck, memCyc, memStb} !== 3'b000)) begin
            reportValue("cpuAck,memCyc,memStb", 32'h0, {29'b0, cpuAck, memCyc, memStb});
        end
        if (!rstN) begin
            for (int i = 0; i < memDepth; i++) begin
                archMem[i] = initialWord(32'(i));
            end
            fifoAdr.delete();
            fifoDat.delete();
            pending = 1'b0;
        end else begin
            // ==============================
            // request, drain, ack
            // ==============================
            if (cpuCyc && cpuStb && !pending) begin
                idx         = findEntry(cpuAdr);
                pending     = 1'b1;
                startCycle  = cycle;
                reqAdr      = cpuAdr;
                reqWe       = cpuWe;
                sawDrain    = 1'b0;
                expectDrain = cpuWe && (fifoAdr.size() == numEntries) && (idx < 0);
                // a drain already on the bus delays any request.
                expectTwo   = !memCyc && (cpuWe ? !expectDrain : (idx >= 0));
            end
            if (memCyc && memStb && memWe && memAck) begin
                sawDrain = 1'b1;
                if (fifoAdr.size() == 0) begin
                    reportOther("memory write with no buffered store");
                end else begin
                    if (memAdr !== fifoAdr[0]) reportValue("memAdr", fifoAdr[0], memAdr);
                    if (memDatW !== fifoDat[0]) reportValue("memDatW", fifoDat[0], memDatW);
                    void'(fifoAdr.pop_front());
                    void'(fifoDat.pop_front());
                end
            end
            if (pending && cpuAck) begin
                if (expectTwo && ((cycle - startCycle) != 2)) begin
                    reportValue("cpuAck latency", 32'd2, cycle - startCycle);
                end
                if (reqWe) begin
                    if (expectDrain && !sawDrain) begin
                        reportOther("store into a full buffer acked before the oldest entry drained");
                    end
                    archMem[reqAdr[7:0]] = cpuDatW;
                    idx = findEntry(reqAdr);
                    if (idx >= 0) begin
                        fifoDat[idx] = cpuDatW;
                    end else if (fifoAdr.size() < numEntries) begin
                        fifoAdr.push_back(reqAdr);
                        fifoDat.push_back(cpuDatW);
                    end else begin
                        reportOther("store acked while every entry was still occupied");
                    end
                end else if (cpuDatR !== archMem[reqAdr[7:0]]) begin
                    reportValue("cpuDatR", archMem[reqAdr[7:0]], cpuDatR);
                end
                pending = 1'b0;
            end
        end
        if (finalCheck) begin
            for (int i = 0; i < memDepth; i++) begin
                if (memImage[i] !== archMem[i]) begin
                    reportValue($sformatf("memArray[%0h]", i), archMem[i], memImage[i]);
                end
            end
            if (fifoAdr.size() != 0) reportOther("stores still buffered after the final idle period");
        end
        rstPrev = !rstN;
    end

endmodule

/* tb/storeBufferTb.sv */
`timescale 1ns/1ns

module storeBufferTb;

    localparam int numEntries = 4;
    localparam int numTrans   = 200;
    localparam int memDepth   = 256;
    // long enough for every entry to drain on its own.
    localparam int drainWait  = 150;

    logic        clk;
    logic        rstN;
    logic        cpuCyc;
    logic        cpuStb;
    logic        cpuWe;
    logic [31:0] cpuAdr;
    logic [31:0] cpuDatW;
    logic [31:0] cpuDatR;
    logic        cpuAck;
    logic        memCyc;
    logic        memStb;
    logic        memWe;
    logic [31:0] memAdr;
    logic [31:0] memDatW;
    logic [31:0] memDatR;
    logic        memAck;
    logic        finalCheck;
    logic [31:0] memArray [memDepth];
    int          valueErrors;
    int          otherErrors;
    int          seed = 86481;
    // the memory slave draws from its own stream.
    int          memSeed = 86481;

    storeBufferTop #(
        .numEntries (numEntries)
    ) storeBufferTop_inst (.*);

    storeBufferChecker #(
        .numEntries (numEntries),
        .memDepth   (memDepth)
    ) storeBufferChecker_inst (
        .*,
        .memImage (memArray)
    );

    // eight words, so hits and coalescing are common.
    function automatic logic [31:0] poolAddress(input logic [2:0] idx);
        return 32'h40 + 32'(idx) * 32'h9;
    endfunction

    function automatic logic [31:0] fillWord(input logic [31:0] adr);
        return (adr * 32'h9E3779B1) ^ 32'hC3A50000;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==============================
    // memory slave
    // ==============================
    initial begin
        int          waitLeft;
        logic [31:0] rnd;
        waitLeft = -1;
        memAck   = 1'b0;
        memDatR  = '0;
        for (int i = 0; i < memDepth; i++) begin
            memArray[i] = fillWord(32'(i));
        end
        forever begin
            @(posedge clk);
            #1;
            if (memAck) begin
                memAck = 1'b0;
            end else if (rstN && memCyc && memStb) begin
                if (waitLeft < 0) begin
                    rnd      = $random(memSeed);
                    waitLeft = int'(rnd[1:0]);
                end
                if (waitLeft == 0) begin
                    if (memWe) begin
                        memArray[memAdr[7:0]] = memDatW;
                    end else begin
                        memDatR = memArray[memAdr[7:0]];
                    end
                    memAck = 1'b1;
                end
                waitLeft--;
            end
        end
    end

    // ==============================
    // cpu stimulus
    // ==============================
    initial begin
        logic [31:0] rnd;
        int          totalErrors;
        rstN       = 1'b0;
        cpuCyc     = 1'b0;
        cpuStb     = 1'b0;
        cpuWe      = 1'b0;
        cpuAdr     = '0;
        cpuDatW    = '0;
        finalCheck = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        for (int t = 0; t < numTrans; t++) begin
            rnd     = $random(seed);
            cpuWe   = rnd[0];
            cpuAdr  = poolAddress(rnd[4:2]);
            cpuDatW = $random(seed);
            cpuCyc  = 1'b1;
            cpuStb  = 1'b1;
            while (!cpuAck) begin
                @(posedge clk);
                #1;
            end
            @(posedge clk);
            #1;
            cpuCyc = 1'b0;
            cpuStb = 1'b0;
            rnd    = $random(seed);
            repeat (int'(rnd % 13) + 1) begin
                @(posedge clk);
                #1;
            end
        end
        repeat (drainWait) @(posedge clk);
        #1;
        finalCheck = 1'b1;
        @(posedge clk);
        #1;
        finalCheck = 1'b0;
        @(posedge clk);
        #1;
        totalErrors = valueErrors + otherErrors +
                      storeBufferTop_inst.storeBufferTopProps_inst.failCount;
        $display("errors: wrong value %0d, other %0d, assertion %0d", valueErrors, otherErrors,
                 storeBufferTop_inst.storeBufferTopProps_inst.failCount);
        if (totalErrors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (numTrans * 40) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", numTrans * 40);
        $display("Verification failed");
        $finish;
    end

endmodule

/* verilog.f */
verilog/sbPkg.sv
verilog/storeBufferEntries.sv
verilog/drainTimer.sv
verilog/sbController.sv
verilog/storeBufferTop.sv
tb/storeBufferTop_props.sv
tb/storeBufferChecker.sv
tb/storeBufferTb.sv

/* run.sh */
#!/bin/sh
# compile with verilator, run, then look for the pass line in the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module storeBufferTb -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Verification passed" sim.log && exit 0 || exit 1
